// File: filelist.f
logic/dispatch_pkg.sv
logic/dispatch_ctl.sv
logic/cpu_pool_regs.sv
logic/mem_proxy.sv
logic/cpu_dispatcher.sv
sim/clk_gen.sv
sim/tb_cpu_dispatcher.sv

// File: logic/cpu_dispatcher.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_dispatcher
  import dispatch_pkg::*;
(
  input  logic              clk,
  input  logic              ext_rst_e,
  // processor side
  input  logic [MSG_W-1:0]  cpu_msg_in,
  input  logic              ext_cpu_e,
  input  logic              read_q,
  input  logic              write_q,
  input  logic [ADDR_W-1:0] addr_in,
  input  logic [DATA_W-1:0] data_in,
  input  logic              rw_halt_in,
  // external memory side
  input  logic              ext_read_dn,
  input  logic              ext_write_dn,
  input  logic [ADDR_W-1:0] ext_mem_addr_in,
  input  logic [DATA_W-1:0] ext_mem_data_in,
  input  logic              ext_rw_halt_in,
  // external bus master
  input  logic              ext_bus_q,
  output logic              rst_out,
  output logic              ext_rst_b,
  output logic [DATA_W-1:0] ext_cpu_index,
  output logic              ext_cpu_q,
  output logic [MSG_W-1:0]  cpu_msg_out,
  output logic              ext_read_q,
  output logic              ext_write_q,
  output logic [ADDR_W-1:0] ext_mem_addr_out,
  output logic [DATA_W-1:0] ext_mem_data_out,
  output logic              read_dn,
  output logic              write_dn,
  output logic [ADDR_W-1:0] addr_out,
  output logic [DATA_W-1:0] data_out,
  output logic              rw_halt_out,
  output logic              ext_rw_halt_out,
  output logic              ext_bus_allow
);

  // controller to pool
  logic reset_ack;
  logic select;
  logic cpu_start;
  logic cpu_end;
  logic reset_done;
  // controller to proxy
  logic start_read;
  logic start_write;
  logic mem_done;

  // no dispatcher-to-processor messages here
  assign cpu_msg_out = MSG_NONE;

  dispatch_ctl dispatch_ctl_i (
    .clk          (clk),
    .ext_rst_e    (ext_rst_e),
    .cpu_msg_in   (cpu_msg_in),
    .ext_cpu_e    (ext_cpu_e),
    .read_q       (read_q),
    .write_q      (write_q),
    .ext_bus_q    (ext_bus_q),
    .reset_done   (reset_done),
    .mem_done     (mem_done),
    .rst_out      (rst_out),
    .ext_rst_b    (ext_rst_b),
    .ext_cpu_q    (ext_cpu_q),
    .ext_bus_allow(ext_bus_allow),
    .reset_ack    (reset_ack),
    .select       (select),
    .cpu_start    (cpu_start),
    .cpu_end      (cpu_end),
    .start_read   (start_read),
    .start_write  (start_write)
  );

  cpu_pool_regs cpu_pool_regs_i (
    .clk          (clk),
    .ext_rst_e    (ext_rst_e),
    .reset_ack    (reset_ack),
    .select       (select),
    .cpu_start    (cpu_start),
    .cpu_end      (cpu_end),
    .ext_cpu_index(ext_cpu_index),
    .reset_done   (reset_done)
  );

  mem_proxy mem_proxy_i (
    .clk             (clk),
    .ext_rst_e       (ext_rst_e),
    .start_read      (start_read),
    .start_write     (start_write),
    .addr_in         (addr_in),
    .data_in         (data_in),
    .ext_read_dn     (ext_read_dn),
    .ext_write_dn    (ext_write_dn),
    .ext_mem_addr_in (ext_mem_addr_in),
    .ext_mem_data_in (ext_mem_data_in),
    .rw_halt_in      (rw_halt_in),
    .ext_rw_halt_in  (ext_rw_halt_in),
    .ext_read_q      (ext_read_q),
    .ext_write_q     (ext_write_q),
    .ext_mem_addr_out(ext_mem_addr_out),
    .ext_mem_data_out(ext_mem_data_out),
    .read_dn         (read_dn),
    .write_dn        (write_dn),
    .addr_out        (addr_out),
    .data_out        (data_out),
    .rw_halt_out     (rw_halt_out),
    .ext_rw_halt_out (ext_rw_halt_out),
    .mem_done        (mem_done)
  );

endmodule

`default_nettype wire

// File: logic/cpu_pool_regs.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_pool_regs
  import dispatch_pkg::*;
(
  input  logic              clk,
  input  logic              ext_rst_e,
  input  logic              reset_ack,
  input  logic              select,
  input  logic              cpu_start,
  input  logic              cpu_end,
  output logic [DATA_W-1:0] ext_cpu_index,
  output logic              reset_done
);

  // started and not-yet-started processors
  logic [CNT_W-1:0] act_cnt;
  logic [CNT_W-1:0] idle_cnt;
  // round-robin position in the active set
  logic [CNT_W-1:0] ptr;
  logic [CNT_W-1:0] ptr_nxt;
  // last poll went to the idle slot
  logic idle_offered;
  // still collecting reset acks
  logic ack_phase;
  logic take_idle;

  cpu_index_u index;
  cpu_index_u sel_index;

  // index register doubles as the ack counter
  assign reset_done = !ack_phase || (index.raw == DATA_W'(CPU_QUANTITY));
  assign ext_cpu_index = index.raw;

  // new processor gets a turn before the next active one
  assign take_idle = ((idle_cnt != '0) && !idle_offered) || (act_cnt == '0);
  // wrap past the last active processor
  assign ptr_nxt = (ptr >= act_cnt - CNT_W'(1)) ? '0 : ptr + CNT_W'(1);

  // compose the next index through the field view
  always_comb begin
    sel_index.raw = '0;
    if (take_idle) begin
      sel_index.fields.idle = 1'b1;
    end else begin
      sel_index.fields.active = 1'b1;
      sel_index.fields.num = ptr_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      act_cnt <= '0;
      idle_cnt <= CNT_W'(CPU_QUANTITY);
      ptr <= '0;
      idle_offered <= 1'b0;
      ack_phase <= 1'b1;
      index.raw <= '0;
    end else if (ack_phase) begin
      // pool full, index back to 0 for polling
      if (reset_done) begin
        index.raw <= '0;
        ack_phase <= 1'b0;
      end else if (reset_ack) begin
        index.raw <= index.raw + DATA_W'(1);
      end
    end else if (select) begin
      index <= sel_index;
      idle_offered <= take_idle;
      if (!take_idle) begin
        ptr <= ptr_nxt;
      end
    end else if (cpu_start) begin
      act_cnt <= act_cnt + CNT_W'(1);
      idle_cnt <= idle_cnt - CNT_W'(1);
      ptr <= ptr + CNT_W'(1);
    end else if (cpu_end) begin
      act_cnt <= act_cnt - CNT_W'(1);
      idle_cnt <= idle_cnt + CNT_W'(1);
    end
  end

endmodule

`default_nettype wire

// File: logic/dispatch_ctl.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_ctl
  import dispatch_pkg::*;
(
  input  logic             clk,
  input  logic             ext_rst_e,
  input  logic [MSG_W-1:0] cpu_msg_in,
  input  logic             ext_cpu_e,
  input  logic             read_q,
  input  logic             write_q,
  input  logic             ext_bus_q,
  // level from the pool, all acks seen
  input  logic             reset_done,
  // pulse from the proxy, operation over
  input  logic             mem_done,
  output logic             rst_out,
  output logic             ext_rst_b,
  output logic             ext_cpu_q,
  output logic             ext_bus_allow,
  // one-cycle strobes to the pool
  output logic             reset_ack,
  output logic             select,
  output logic             cpu_start,
  output logic             cpu_end,
  // one-cycle strobes to the proxy
  output logic             start_read,
  output logic             start_write
);

  ctl_state_e state;

  // state decode
  logic in_reset_wait;
  logic in_loop;
  logic in_cmd;
  // processor reply with a message, no memory request
  logic msg_take;

  assign in_reset_wait = (state == RESET_WAIT);
  assign in_loop = (state == CPU_LOOP);
  assign in_cmd = (state == CPU_CMD);

  // count reset messages until the pool is full
  assign reset_ack = in_reset_wait && !reset_done && (cpu_msg_in == MSG_RESET);

  // bus request wins over polling
  // poll only while no processor is still answering
  assign select = in_loop && !ext_bus_q && !ext_cpu_e;

  // read over write over message
  assign start_read = in_cmd && read_q;
  assign start_write = in_cmd && !read_q && write_q;
  assign msg_take = in_cmd && !read_q && !write_q && ext_cpu_e;

  // unknown codes just end the command
  assign cpu_start = msg_take && (cpu_msg_in == MSG_START);
  assign cpu_end = msg_take && (cpu_msg_in == MSG_END);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state <= RESET_WAIT;
      rst_out <= 1'b1;
      ext_rst_b <= 1'b1;
      ext_cpu_q <= 1'b0;
      ext_bus_allow <= 1'b0;
    end else begin
      // poll strobe lasts one cycle, index loads on the same edge
      ext_cpu_q <= select;

      case (state)
        RESET_WAIT: begin
          // all processors acked, release them
          if (reset_done) begin
            rst_out <= 1'b0;
            ext_rst_b <= 1'b0;
            state <= CPU_LOOP;
          end
        end

        CPU_LOOP: begin
          if (ext_bus_q) begin
            state <= EXT_BUS;
          end else if (select) begin
            state <= CPU_CMD;
          end
        end

        CPU_CMD: begin
          // no limit on how long the processor takes
          if (start_read || start_write) begin
            state <= MEM_WORK;
          end else if (msg_take) begin
            state <= CPU_LOOP;
          end
        end

        MEM_WORK: begin
          // done, halt or timeout all end here
          if (mem_done) begin
            state <= CPU_LOOP;
          end
        end

        EXT_BUS: begin
          // grant follows the request one edge late
          if (ext_bus_q) begin
            ext_bus_allow <= 1'b1;
          end else begin
            ext_bus_allow <= 1'b0;
            state <= CPU_LOOP;
          end
        end

        default: begin
          state <= CPU_LOOP;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // processor message width
  localparam int MSG_W = 8;

  // processors in the pool
  localparam int CPU_QUANTITY = 4;
  // counts and round-robin pointer
  localparam int CNT_W = 3;

  // processor message codes, anything else is ignored
  localparam logic [MSG_W-1:0] MSG_NONE = MSG_W'(0);
  localparam logic [MSG_W-1:0] MSG_RESET = MSG_W'(1);
  localparam logic [MSG_W-1:0] MSG_START = MSG_W'(2);
  localparam logic [MSG_W-1:0] MSG_END = MSG_W'(3);

  // idle memory cycles tolerated before both halts fire
  localparam int MEM_TIMEOUT = 50;
  // counter has to reach MEM_TIMEOUT + 1
  localparam int TMO_W = $clog2(MEM_TIMEOUT + 2);

  // controller states
  typedef enum logic [2:0] {
    RESET_WAIT,
    CPU_LOOP,
    CPU_CMD,
    MEM_WORK,
    EXT_BUS
  } ctl_state_e;

  // processor index word
  // raw view leaves the chip, field view is how the pool builds it
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      // slot of a started processor
      logic active;
      // slot offered to a processor not yet started
      logic idle;
      logic [DATA_W-3-CNT_W:0] pad;
      // processor number within the active set
      logic [CNT_W-1:0] num;
    } fields;
  } cpu_index_u;

endpackage

`default_nettype wire

// File: logic/mem_proxy.sv
`timescale 1ns/100ps
`default_nettype none

module mem_proxy
  import dispatch_pkg::*;
(
  input  logic              clk,
  input  logic              ext_rst_e,
  input  logic              start_read,
  input  logic              start_write,
  // request from the polled processor
  input  logic [ADDR_W-1:0] addr_in,
  input  logic [DATA_W-1:0] data_in,
  // external memory answers
  input  logic              ext_read_dn,
  input  logic              ext_write_dn,
  input  logic [ADDR_W-1:0] ext_mem_addr_in,
  input  logic [DATA_W-1:0] ext_mem_data_in,
  // halt from the processor, halt from the memory
  input  logic              rw_halt_in,
  input  logic              ext_rw_halt_in,
  output logic              ext_read_q,
  output logic              ext_write_q,
  output logic [ADDR_W-1:0] ext_mem_addr_out,
  output logic [DATA_W-1:0] ext_mem_data_out,
  output logic              read_dn,
  output logic              write_dn,
  output logic [ADDR_W-1:0] addr_out,
  output logic [DATA_W-1:0] data_out,
  output logic              rw_halt_out,
  output logic              ext_rw_halt_out,
  output logic              mem_done
);

  logic pend_rd;
  logic pend_wr;
  logic pending;
  // latched request
  logic [ADDR_W-1:0] addr_lat;
  logic [DATA_W-1:0] data_lat;
  // idle cycles of the current operation
  logic [TMO_W-1:0] tmo_cnt;
  logic timed_out;
  logic rd_hit;
  logic wr_hit;

  assign pending = pend_rd || pend_wr;
  assign timed_out = (tmo_cnt > TMO_W'(MEM_TIMEOUT));
  assign rd_hit = pend_rd && ext_read_dn;
  assign wr_hit = pend_wr && ext_write_dn;

  // address only shown while the operation is open
  assign ext_mem_addr_out = pending ? addr_lat : '0;
  assign ext_mem_data_out = data_lat;

  // request payload
  always_ff @(posedge clk) begin
    if (start_read || start_write) begin
      addr_lat <= addr_in;
    end
    if (start_write) begin
      data_lat <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      pend_rd <= 1'b0;
      pend_wr <= 1'b0;
      tmo_cnt <= '0;
      ext_read_q <= 1'b0;
      ext_write_q <= 1'b0;
      read_dn <= 1'b0;
      write_dn <= 1'b0;
      rw_halt_out <= 1'b0;
      ext_rw_halt_out <= 1'b0;
      mem_done <= 1'b0;
      addr_out <= '0;
      data_out <= '0;
    end else begin
      // all strobes are single cycle
      ext_read_q <= 1'b0;
      ext_write_q <= 1'b0;
      read_dn <= 1'b0;
      write_dn <= 1'b0;
      rw_halt_out <= 1'b0;
      ext_rw_halt_out <= 1'b0;
      mem_done <= 1'b0;
      // returned word lasts only for the done cycle
      addr_out <= '0;
      data_out <= '0;

      if (start_read) begin
        pend_rd <= 1'b1;
        ext_read_q <= 1'b1;
        tmo_cnt <= '0;
      end else if (start_write) begin
        pend_wr <= 1'b1;
        ext_write_q <= 1'b1;
        tmo_cnt <= '0;
      end else if (pending) begin
        // fixed priority, first match ends the operation
        if (rw_halt_in) begin
          ext_rw_halt_out <= 1'b1;
        end else if (ext_rw_halt_in) begin
          rw_halt_out <= 1'b1;
        end else if (timed_out) begin
          // nobody answered, stop both sides
          ext_rw_halt_out <= 1'b1;
          rw_halt_out <= 1'b1;
        end else if (rd_hit) begin
          read_dn <= 1'b1;
          addr_out <= ext_mem_addr_in;
          data_out <= ext_mem_data_in;
        end else if (wr_hit) begin
          write_dn <= 1'b1;
          addr_out <= ext_mem_addr_in;
          data_out <= ext_mem_data_in;
        end

        if (rw_halt_in || ext_rw_halt_in || timed_out || rd_hit || wr_hit) begin
          pend_rd <= 1'b0;
          pend_wr <= 1'b0;
          tmo_cnt <= '0;
          mem_done <= 1'b1;
        end else begin
          tmo_cnt <= tmo_cnt + TMO_W'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic ext_rst_e
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset held over the first few rising edges
  initial begin
    ext_rst_e = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    ext_rst_e <= 1'b0;
  end

endmodule

`default_nettype wire

// File: sim/tb_cpu_dispatcher.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_dispatcher
  import dispatch_pkg::*;
();

  // events the main flow waits for
  localparam int EV_RUN = 0;
  localparam int EV_RST_LOW = 1;
  localparam int EV_POLL = 2;
  localparam int EV_RD_Q = 3;
  localparam int EV_WR_Q = 4;
  localparam int EV_RD_DN = 5;
  localparam int EV_WR_DN = 6;
  localparam int EV_HALT = 7;
  localparam int EV_EXT_HALT = 8;
  localparam int EV_BOTH_HALT = 9;
  localparam int EV_GRANT = 10;
  localparam int EV_FREE = 11;

  logic clk;
  logic ext_rst_e;
  logic [MSG_W-1:0] cpu_msg_in;
  logic ext_cpu_e;
  logic read_q;
  logic write_q;
  logic [ADDR_W-1:0] addr_in;
  logic [DATA_W-1:0] data_in;
  logic rw_halt_in;
  logic ext_read_dn;
  logic ext_write_dn;
  logic [ADDR_W-1:0] ext_mem_addr_in;
  logic [DATA_W-1:0] ext_mem_data_in;
  logic ext_rw_halt_in;
  logic ext_bus_q;
  logic rst_out;
  logic ext_rst_b;
  logic [DATA_W-1:0] ext_cpu_index;
  logic ext_cpu_q;
  logic [MSG_W-1:0] cpu_msg_out;
  logic ext_read_q;
  logic ext_write_q;
  logic [ADDR_W-1:0] ext_mem_addr_out;
  logic [DATA_W-1:0] ext_mem_data_out;
  logic read_dn;
  logic write_dn;
  logic [ADDR_W-1:0] addr_out;
  logic [DATA_W-1:0] data_out;
  logic rw_halt_out;
  logic ext_rw_halt_out;
  logic ext_bus_allow;

  // pool model of counts and round-robin state
  int m_act;
  int m_idle;
  int m_ptr;
  bit m_offered;
  bit prev_poll;
  // request currently in flight
  logic [ADDR_W-1:0] exp_addr;
  logic [DATA_W-1:0] exp_data;
  logic [31:0] rng;
  int errors;
  int err_mark;
  int test_num;
  int tests_ok;
  int tests_bad;

  // scripted processor replies for the selection test
  logic [MSG_W-1:0] script [0:11] = '{MSG_START, MSG_START, MSG_NONE, MSG_START,
    MSG_END, 8'h07, MSG_START, MSG_START, MSG_NONE, MSG_END, MSG_END, MSG_NONE};

  clk_gen #(.PERIOD(100), .RST_CYCLES(3)) clk_gen_i (.clk(clk), .ext_rst_e(ext_rst_e));

  cpu_dispatcher cpu_dispatcher_i (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory contents derived from the whole address
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
    return (a ^ 32'hA5C3_0F1E) + {a[15:0], a[31:16]};
  endfunction

  // a not yet started processor goes first unless it just had its turn
  function automatic bit idle_turn(input int act, input int idle, input bit offered);
    return ((idle != 0) && !offered) || (act == 0);
  endfunction

  function automatic int ptr_step(input int ptr, input int act);
    return (ptr + 1 < act) ? ptr + 1 : 0;
  endfunction

  function automatic logic [DATA_W-1:0] expected_index(input int act, input int idle,
                                                      input int ptr, input bit offered);
    logic [DATA_W-1:0] idx;
    idx = '0;
    if (idle_turn(act, idle, offered)) begin
      idx[DATA_W-2] = 1'b1;
    end else begin
      idx[DATA_W-1] = 1'b1;
      idx[CNT_W-1:0] = CNT_W'(ptr_step(ptr, act));
    end
    return idx;
  endfunction

  function automatic bit probe(input int ev);
    case (ev)
      EV_RUN: return ext_rst_e === 1'b0;
      EV_RST_LOW: return rst_out === 1'b0;
      EV_POLL: return ext_cpu_q === 1'b1;
      EV_RD_Q: return ext_read_q === 1'b1;
      EV_WR_Q: return ext_write_q === 1'b1;
      EV_RD_DN: return read_dn === 1'b1;
      EV_WR_DN: return write_dn === 1'b1;
      EV_HALT: return rw_halt_out === 1'b1;
      EV_EXT_HALT: return ext_rw_halt_out === 1'b1;
      EV_BOTH_HALT: return (rw_halt_out === 1'b1) && (ext_rw_halt_out === 1'b1);
      EV_GRANT: return ext_bus_allow === 1'b1;
      default: return ext_bus_allow === 1'b0;
    endcase
  endfunction

  task automatic report_value(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
    $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    errors++;
  endtask

  task automatic report_text(input string what);
    $display("error: %s", what);
    errors++;
  endtask

  task automatic print_counts();
    $display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
  endtask

  task automatic abort_run(input string why);
    $display("error: %s", why);
    print_counts();
    $display("Testbench failed");
    $finish;
  endtask

  // sampled on falling edges
  task automatic await_event(input int ev, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!probe(ev) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!probe(ev)) begin
      abort_run({"timed out waiting for ", what});
    end
  endtask

  task automatic end_test(input string name);
    @(posedge clk);
    test_num++;
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %0d %s: pass", test_num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: fail with %0d errors", test_num, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic send_reset_ack();
    @(posedge clk);
    cpu_msg_in <= MSG_RESET;
    @(posedge clk);
    cpu_msg_in <= MSG_NONE;
  endtask

  // processor reply to a poll and the matching model update
  task automatic answer_msg(input logic [MSG_W-1:0] msg);
    @(posedge clk);
    ext_cpu_e <= 1'b1;
    cpu_msg_in <= msg;
    if (msg == MSG_START) begin
      m_act++;
      m_idle--;
      m_ptr = (m_ptr + 1) % (1 << CNT_W);
    end else if (msg == MSG_END) begin
      m_act--;
      m_idle++;
    end
    @(posedge clk);
    ext_cpu_e <= 1'b0;
    cpu_msg_in <= MSG_NONE;
  endtask

  task automatic mem_request(input bit is_write, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d);
    @(posedge clk);
    exp_addr = a;
    exp_data = d;
    addr_in <= a;
    data_in <= d;
    if (is_write) begin
      write_q <= 1'b1;
    end else begin
      read_q <= 1'b1;
    end
    @(posedge clk);
    read_q <= 1'b0;
    write_q <= 1'b0;
    if (is_write) begin
      await_event(EV_WR_Q, 10, "ext_write_q");
      assert (ext_mem_data_out === d) else report_value("ext_mem_data_out", ext_mem_data_out, d);
    end else begin
      await_event(EV_RD_Q, 10, "ext_read_q");
    end
    assert (ext_mem_addr_out === a) else report_value("ext_mem_addr_out", ext_mem_addr_out, a);
    @(negedge clk);
    assert (!ext_read_q && !ext_write_q) else report_text("memory strobe longer than one cycle");
  endtask

  // external memory answers after a few cycles
  task automatic mem_respond(input bit is_write, input int lat);
    repeat (lat) @(posedge clk);
    @(posedge clk);
    ext_mem_addr_in <= exp_addr;
    if (is_write) begin
      ext_write_dn <= 1'b1;
      ext_mem_data_in <= exp_data;
    end else begin
      ext_read_dn <= 1'b1;
      ext_mem_data_in <= mem_word(exp_addr);
    end
    @(posedge clk);
    ext_read_dn <= 1'b0;
    ext_write_dn <= 1'b0;
    ext_mem_addr_in <= '0;
    ext_mem_data_in <= '0;
  endtask

  task automatic mem_access(input bit is_write);
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    rng = lcg_next(rng);
    a = rng;
    rng = lcg_next(rng);
    d = rng;
    mem_request(is_write, a, d);
    mem_respond(is_write, int'(rng[17:16]));
    if (is_write) begin
      await_event(EV_WR_DN, 20, "write_dn");
    end else begin
      await_event(EV_RD_DN, 20, "read_dn");
    end
    // finish cycle clears the returned word
    @(negedge clk);
    assert (addr_out === '0 && data_out === '0) else report_text("returned word not cleared");
    // no address on the memory bus once the operation is over
    assert (ext_mem_addr_out === '0)
      else report_value("ext_mem_addr_out", ext_mem_addr_out, '0);
    await_event(EV_POLL, 10, "poll after memory access");
  endtask

  // halt arrives together with a read answer and takes priority
  task automatic pulse_halt(input bit from_memory);
    @(posedge clk);
    if (from_memory) begin
      ext_rw_halt_in <= 1'b1;
    end else begin
      rw_halt_in <= 1'b1;
    end
    ext_read_dn <= 1'b1;
    ext_mem_addr_in <= exp_addr;
    ext_mem_data_in <= mem_word(exp_addr);
    @(posedge clk);
    rw_halt_in <= 1'b0;
    ext_rw_halt_in <= 1'b0;
    ext_read_dn <= 1'b0;
    ext_mem_addr_in <= '0;
    ext_mem_data_in <= '0;
  endtask

  // compare process for polls and returned data
  always @(negedge clk) begin
    logic [DATA_W-1:0] exp_idx;
    if (ext_rst_e === 1'b0) begin
      if (ext_cpu_q === 1'b1) begin
        exp_idx = expected_index(m_act, m_idle, m_ptr, m_offered);
        assert (ext_cpu_index === exp_idx)
          else report_value("ext_cpu_index", ext_cpu_index, exp_idx);
        assert (!prev_poll) else report_text("ext_cpu_q high for more than one cycle");
        if (idle_turn(m_act, m_idle, m_offered)) begin
          m_offered = 1'b1;
        end else begin
          m_ptr = ptr_step(m_ptr, m_act);
          m_offered = 1'b0;
        end
      end
      if (read_dn === 1'b1 || write_dn === 1'b1) begin
        exp_idx = (read_dn === 1'b1) ? mem_word(exp_addr) : exp_data;
        assert (addr_out === exp_addr) else report_value("addr_out", addr_out, exp_addr);
        assert (data_out === exp_idx) else report_value("data_out", data_out, exp_idx);
      end
      prev_poll = (ext_cpu_q === 1'b1);
    end
  end

  initial begin
    cpu_msg_in <= MSG_NONE;
    ext_cpu_e <= 1'b0;
    read_q <= 1'b0;
    write_q <= 1'b0;
    addr_in <= '0;
    data_in <= '0;
    rw_halt_in <= 1'b0;
    ext_read_dn <= 1'b0;
    ext_write_dn <= 1'b0;
    ext_mem_addr_in <= '0;
    ext_mem_data_in <= '0;
    ext_rw_halt_in <= 1'b0;
    ext_bus_q <= 1'b0;
    m_act = 0;
    m_idle = CPU_QUANTITY;
    m_ptr = 0;
    m_offered = 1'b0;
    prev_poll = 1'b0;
    rng = 32'd21421;
    errors = 0;
    err_mark = 0;
    test_num = 0;
    tests_ok = 0;
    tests_bad = 0;

    // outputs while reset is still applied
    @(posedge clk);
    @(negedge clk);
    assert (!ext_cpu_q && !ext_read_q && !ext_write_q && !ext_bus_allow && !read_dn && !write_dn)
      else report_text("strobes not low during reset");
    assert (rst_out === 1'b1 && ext_rst_b === 1'b1)
      else report_text("reset outputs low during reset");
    assert (ext_cpu_index === '0) else report_value("ext_cpu_index", ext_cpu_index, '0);
    assert (cpu_msg_out === MSG_NONE) else report_value("cpu_msg_out", cpu_msg_out, MSG_NONE);
    await_event(EV_RUN, 10, "reset release");
    repeat (CPU_QUANTITY - 1) send_reset_ack();
    @(negedge clk);
    assert (rst_out === 1'b1) else report_text("rst_out fell before all acknowledges");
    send_reset_ack();
    await_event(EV_RST_LOW, 10, "rst_out release");
    assert (ext_rst_b === 1'b0) else report_text("ext_rst_b still high after reset wait");
    await_event(EV_POLL, 10, "first poll");
    end_test("reset wait");

    for (int i = 0; i < 12; i++) begin
      answer_msg(script[i]);
      await_event(EV_POLL, 10, "poll after message");
    end
    end_test("selection");

    repeat (4) mem_access(1'b0);
    end_test("memory read");

    repeat (4) mem_access(1'b1);
    end_test("memory write");

    // processor side halt
    rng = lcg_next(rng);
    mem_request(1'b0, rng, '0);
    pulse_halt(1'b0);
    await_event(EV_EXT_HALT, 10, "ext_rw_halt_out");
    assert (!read_dn && !rw_halt_out) else report_text("processor halt raised another strobe");
    await_event(EV_POLL, 10, "poll after processor halt");
    // memory side halt
    rng = lcg_next(rng);
    mem_request(1'b0, rng, '0);
    pulse_halt(1'b1);
    await_event(EV_HALT, 10, "rw_halt_out");
    assert (!read_dn && !ext_rw_halt_out) else report_text("memory halt raised another strobe");
    await_event(EV_POLL, 10, "poll after memory halt");
    // silent memory
    rng = lcg_next(rng);
    mem_request(1'b0, rng, '0);
    await_event(EV_BOTH_HALT, MEM_TIMEOUT + 10, "timeout halts");
    assert (!read_dn) else report_text("read_dn came with the timeout halts");
    await_event(EV_POLL, 10, "poll after timeout");
    end_test("halts and timeout");

    @(posedge clk);
    ext_bus_q <= 1'b1;
    answer_msg(MSG_NONE);
    await_event(EV_GRANT, 10, "ext_bus_allow");
    repeat (5) begin
      @(negedge clk);
      assert (ext_bus_allow === 1'b1) else report_text("ext_bus_allow dropped while requested");
      assert (ext_cpu_q === 1'b0) else report_text("processor polled during bus grant");
    end
    @(posedge clk);
    ext_bus_q <= 1'b0;
    await_event(EV_FREE, 10, "ext_bus_allow release");
    await_event(EV_POLL, 10, "poll after bus release");
    end_test("bus grant");

    print_counts();
    if (errors == 0 && tests_bad == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
